//--- verilog/dense_pkg.sv
// Dense layer package with default sizes, weight and accumulator types, sequencer states
package dense_pkg;

  // Default image and layer sizes
  localparam int N_PIXEL_DEF  = 16;
  localparam int N_NEURON_DEF = 8;

  // Bits per weight or bias entry in the weight file
  localparam int WEIGHT_W = 8;
  localparam int ACC_W    = 16;

  // Signed weight or bias
  typedef logic signed [WEIGHT_W-1:0] weight_t;

  // Accumulator and result, 16 bit like a shortint
  typedef logic signed [ACC_W-1:0] acc_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,   // Waiting for start
    ACCUM,  // Taking in pixels
    FLUSH,  // Last sum settles in the lanes
    READY   // Results held, done raised
  } seq_state_t;

  // One packed row per pixel, then the bias row.
  // Neuron 0 sits in the least significant byte of each row
  localparam string WEIGHT_FILE = "verilog/weights.mem";

endpackage

//--- verilog/mac_if.sv
// Pixel, weight row and lane sum bundle between sequencer, accumulator lanes and drain
interface mac_if #(
  parameter int N_NEURON = dense_pkg::N_NEURON_DEF
);

  logic clear;                         // One cycle pulse after start
  logic en;                            // Pixel strobe towards the lanes
  logic pixel;                         // Registered pixel bit
  logic last;                          // Marks the final pixel of the image
  dense_pkg::weight_t weight [N_NEURON]; // ROM row for the current pixel
  dense_pkg::acc_t    sum    [N_NEURON]; // Running sums, one per lane

  modport feeder (
    output clear, en, pixel, last, weight
  );

  modport lane (
    input  clear, en, pixel, weight,
    output sum
  );

  modport drain (
    input last, sum
  );

endinterface

//--- verilog/pixel_sequencer.sv
// Pixel sequencer with control FSM, pixel and set-pixel counters and weight ROM feeding the lanes
module pixel_sequencer #(
  parameter int N_PIXEL  = dense_pkg::N_PIXEL_DEF,
  parameter int N_NEURON = dense_pkg::N_NEURON_DEF
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic                         pixel_valid,
  input  logic                         pixel,
  output logic                         busy,
  output logic [$clog2(N_PIXEL+1)-1:0] set_count,
  mac_if.feeder                        mac
);

  import dense_pkg::*;

  localparam int CNT_W = $clog2(N_PIXEL + 1);
  localparam int ROW_W = N_NEURON * WEIGHT_W;

  seq_state_t state, next_state;

  logic [ROW_W-1:0] rom [N_PIXEL+1]; // Pixel rows, bias row at the end

  logic [CNT_W-1:0] count;    // Pixels taken so far
  logic             start_ok;
  logic             take;

  // First pipeline stage, the accepted pixel and its ROM index
  logic             take_q;
  logic             pix_q;
  logic             last_q;
  logic [CNT_W-1:0] idx_q;

  initial $readmemh(WEIGHT_FILE, rom);

  assign start_ok = start && (state == IDLE || state == READY);
  // No back-pressure, only the pixel count limits acceptance
  assign take = (state == ACCUM) && pixel_valid && (count != CNT_W'(N_PIXEL));

  always_ff @(posedge clk) begin
    if (reset) state <= IDLE;
    else state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE, READY: if (start_ok) next_state = ACCUM;
      ACCUM:       if (last_q) next_state = FLUSH; // Last pixel now on its way to the lanes
      FLUSH:       next_state = READY;
      default:     next_state = IDLE;
    endcase
  end

  // Counters and status
  always_ff @(posedge clk) begin
    if (reset) begin
      count     <= '0;
      set_count <= '0;
      busy      <= 1'b0;
      mac.clear <= 1'b0;
    end else begin
      mac.clear <= start_ok;
      if (start_ok) begin
        count     <= '0;
        set_count <= '0;
        busy      <= 1'b1;
      end else begin
        if (take) count <= count + 1'b1;
        if (take && pixel) set_count <= set_count + 1'b1;
        if (state == READY) busy <= 1'b0; // Drops as the drain raises done
      end
    end
  end

  // Stage one control
  always_ff @(posedge clk) begin
    if (reset) begin
      take_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      take_q <= take;
      last_q <= take && (count == CNT_W'(N_PIXEL - 1));
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= pixel;
    idx_q <= count;
  end

  // Stage two control, seen by the lanes
  always_ff @(posedge clk) begin
    if (reset) begin
      mac.en   <= 1'b0;
      mac.last <= 1'b0;
    end else begin
      mac.en   <= take_q;
      mac.last <= last_q;
    end
  end

  // Weight row read for the pixel taken one cycle earlier
  always_ff @(posedge clk) begin
    mac.pixel <= pix_q;
    for (int j = 0; j < N_NEURON; j++) begin
      mac.weight[j] <= weight_t'(rom[idx_q][j*WEIGHT_W +: WEIGHT_W]);
    end
  end

endmodule

//--- verilog/neuron_mac.sv
// Accumulator lane that adds its weight to a running sum for every set pixel
module neuron_mac #(
  parameter int LANE     = 0,
  parameter int N_NEURON = dense_pkg::N_NEURON_DEF
) (
  input  logic clk,
  input  logic reset,
  mac_if.lane  mac
);

  import dense_pkg::*;

  acc_t acc;

  if (LANE >= N_NEURON) begin : g_lane_range
    $error("neuron_mac LANE %0d beyond N_NEURON %0d", LANE, N_NEURON);
  end

  // Multiply by a one-bit pixel reduces to a conditional add
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (mac.clear) begin
      acc <= '0; // New image
    end else if (mac.en && mac.pixel) begin
      acc <= acc + acc_t'(mac.weight[LANE]); // Sign extended weight
    end
  end

  assign mac.sum[LANE] = acc;

endmodule

//--- verilog/bias_drain.sv
// Bias drain that subtracts per-neuron biases from the lane sums, latches results, raises done
module bias_drain #(
  parameter int N_PIXEL  = dense_pkg::N_PIXEL_DEF,
  parameter int N_NEURON = dense_pkg::N_NEURON_DEF
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  mac_if.drain            mac,
  output logic            done,
  output dense_pkg::acc_t result [N_NEURON]
);

  import dense_pkg::*;

  localparam int ROW_W = N_NEURON * WEIGHT_W;

  // Same image as the sequencer ROM, only the final row is read here
  logic [ROW_W-1:0] mem [N_PIXEL+1];
  logic [ROW_W-1:0] bias_row;
  weight_t          bias [N_NEURON];

  logic last_d; // Lane sums are final one cycle after last

  initial $readmemh(WEIGHT_FILE, mem);

  assign bias_row = mem[N_PIXEL];

  always_comb begin
    for (int j = 0; j < N_NEURON; j++) begin
      bias[j] = weight_t'(bias_row[j*WEIGHT_W +: WEIGHT_W]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) last_d <= 1'b0;
    else last_d <= mac.last;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b0; // Only high in READY, where start is always taken
    end else if (last_d) begin
      done <= 1'b1;
    end
  end

  // Results hold until the next image finishes
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int j = 0; j < N_NEURON; j++) begin
        result[j] <= '0;
      end
    end else if (last_d) begin
      for (int j = 0; j < N_NEURON; j++) begin
        result[j] <= mac.sum[j] - acc_t'(bias[j]);
      end
    end
  end

endmodule

//--- verilog/dense_layer.sv
// Dense layer top, sequencer feeding N_NEURON accumulator lanes and the bias drain
module dense_layer #(
  parameter int N_PIXEL  = dense_pkg::N_PIXEL_DEF,
  parameter int N_NEURON = dense_pkg::N_NEURON_DEF
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic                         pixel_valid,
  input  logic                         pixel,
  output logic                         busy,
  output logic                         done,
  output logic [$clog2(N_PIXEL+1)-1:0] set_count,
  output dense_pkg::acc_t              result [N_NEURON]
);

  mac_if #(
    .N_NEURON (N_NEURON)
  ) mac ();

  pixel_sequencer #(
    .N_PIXEL  (N_PIXEL),
    .N_NEURON (N_NEURON)
  ) pixel_sequencer_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .busy        (busy),
    .set_count   (set_count),
    .mac         (mac.feeder)
  );

  // One lane per neuron
  for (genvar i = 0; i < N_NEURON; i++) begin : g_lane
    neuron_mac #(
      .LANE     (i),
      .N_NEURON (N_NEURON)
    ) neuron_mac_inst (
      .clk   (clk),
      .reset (reset),
      .mac   (mac.lane)
    );
  end

  bias_drain #(
    .N_PIXEL  (N_PIXEL),
    .N_NEURON (N_NEURON)
  ) bias_drain_inst (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .mac    (mac.drain),
    .done   (done),
    .result (result)
  );

endmodule

//--- sim/dense_layer_props.sv
// Dense layer properties on the handshake, the lane strobe and reset, bound into the top level
module dense_layer_props (
  input logic                  clk,
  input logic                  reset,
  input logic                  busy,
  input logic                  done,
  input logic                  en,
  input dense_pkg::seq_state_t state
);

  import dense_pkg::*;

  // Busy falls at the same edge that raises done
  busy_done_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(busy && done)
  ) else $error("busy and done were high in the same cycle");

  done_low_after_reset: assert property (
    @(posedge clk) reset |=> !done
  ) else $error("done was high in the cycle after reset");

  // Lane strobe only while pixels are in flight
  en_in_accum_or_flush: assert property (
    @(posedge clk) disable iff (reset) en |-> (state == ACCUM || state == FLUSH)
  ) else $error("lane strobe seen outside ACCUM and FLUSH");

endmodule

bind dense_layer dense_layer_props props_inst (
  .clk   (clk),
  .reset (reset),
  .busy  (busy),
  .done  (done),
  .en    (mac.en),
  .state (pixel_sequencer_inst.state)
);

//--- sim/dense_layer_tb.sv
// Dense layer testbench that replays golden images with gaps and checks counts and results
module dense_layer_tb;

  import dense_pkg::*;

  localparam int    N_PIXEL     = N_PIXEL_DEF;
  localparam int    N_NEURON    = N_NEURON_DEF;
  localparam int    CNT_W       = $clog2(N_PIXEL + 1);
  localparam int    MAX_IMG     = 32;
  localparam string GOLDEN_FILE = "sim/dense_layer_golden.txt";

  logic             clk;
  logic             reset;
  logic             start;
  logic             pixel_valid;
  logic             pixel;
  logic             busy;
  logic             done;
  logic [CNT_W-1:0] set_count;
  acc_t             result [N_NEURON];

  // Golden records
  logic [N_PIXEL-1:0] img_bits   [MAX_IMG];
  int                 img_gap    [MAX_IMG][N_PIXEL];
  int                 exp_count  [MAX_IMG];
  acc_t               exp_result [MAX_IMG][N_NEURON];
  int                 n_img;

  int          cycles      = 0;
  int          cycle_limit = 1000000; // Replaced once the golden file is read
  logic [31:0] lcg_state   = 32'd60;

  dense_layer #(
    .N_PIXEL  (N_PIXEL),
    .N_NEURON (N_NEURON)
  ) dense_layer_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .pixel_valid (pixel_valid),
    .pixel       (pixel),
    .busy        (busy),
    .done        (done),
    .set_count   (set_count),
    .result      (result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) fail_run($sformatf("Timeout after %0d cycles", cycles));
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function logic noise_bit();
    lcg_state = lcg_next(lcg_state);
    return lcg_state[16];
  endfunction

  // Pixel line toggles while pixel_valid is low
  task automatic drive_idle();
    start       <= 1'b0;
    pixel_valid <= 1'b0;
    pixel       <= noise_bit();
  endtask

  task automatic read_golden();
    int                 fd;
    int                 code;
    int                 val;
    string              line;
    logic [N_PIXEL-1:0] bits;
    logic [ACC_W-1:0]   hex_val;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      fail_run($sformatf("Could not open golden file %s", GOLDEN_FILE));
    end else begin
      code  = $fgets(line, fd); // Two header lines
      code  = $fgets(line, fd);
      n_img = 0;
      while (n_img < MAX_IMG && $fscanf(fd, "%b", bits) == 1) begin
        for (int p = 0; p < N_PIXEL; p++) begin
          code = $fscanf(fd, "%d", val);
          assert (code == 1)
          else fail_run($sformatf("Golden image %0d lacks a gap count", n_img));
          img_gap[n_img][p] = val;
        end
        code = $fscanf(fd, "%d", val);
        assert (code == 1)
        else fail_run($sformatf("Golden image %0d lacks its set count", n_img));
        exp_count[n_img] = val;
        for (int j = 0; j < N_NEURON; j++) begin
          code = $fscanf(fd, "%h", hex_val);
          assert (code == 1)
          else fail_run($sformatf("Golden image %0d lacks a result", n_img));
          exp_result[n_img][j] = acc_t'(hex_val);
        end
        img_bits[n_img] = bits;
        n_img++;
      end
      $fclose(fd);
    end
  endtask

  task automatic check_results(input int k);
    for (int j = 0; j < N_NEURON; j++) begin
      check_value($sformatf("result[%0d]", j), result[j], exp_result[k][j]);
    end
    check_value("set_count", set_count, exp_count[k]);
  endtask

  task automatic run_image(input int k);
    logic bit_p;
    @(posedge clk);
    start       <= 1'b1;
    pixel_valid <= 1'b0;
    pixel       <= noise_bit();
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_value("done", done, 1'b0); // Start clears done
    check_value("busy", busy, 1'b1);
    check_value("set_count", set_count, 0);
    for (int p = 0; p < N_PIXEL; p++) begin
      repeat (img_gap[k][p]) begin
        @(posedge clk);
        drive_idle();
      end
      bit_p = img_bits[k][N_PIXEL-1-p]; // Pixel 0 is the leftmost character
      @(posedge clk);
      pixel_valid <= 1'b1;
      pixel       <= bit_p;
    end
    // Last pixel is taken at the next edge, done follows three edges later
    for (int t = 1; t <= 4; t++) begin
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_value("done", done, t == 4);
      check_value("busy", busy, t != 4);
    end
    check_results(k);
    repeat (2) begin
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_value("done", done, 1'b1);
      check_results(k);
    end
  endtask

  initial begin
    int total;
    reset       = 1'b1;
    start       = 1'b0;
    pixel_valid = 1'b0;
    pixel       = 1'b0;
    read_golden();
    assert (n_img > 0) else fail_run("Golden file holds no images");
    total = 0;
    for (int k = 0; k < n_img; k++) begin
      assert ($countones(img_bits[k]) == exp_count[k])
      else fail_run($sformatf("Golden set count of image %0d disagrees with its bits", k));
      total += N_PIXEL;
      for (int p = 0; p < N_PIXEL; p++) total += img_gap[k][p];
    end
    cycle_limit = total + 10 * n_img + 50;

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("busy", busy, 1'b0);
    check_value("done", done, 1'b0);
    check_value("set_count", set_count, 0);
    for (int j = 0; j < N_NEURON; j++) begin
      check_value($sformatf("result[%0d]", j), result[j], 0);
    end

    for (int k = 0; k < n_img; k++) begin
      run_image(k);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- verilog/weights.mem
// Weight rows for pixels 0 to 15, then the bias row
// Each row packs neurons 7 down to 0, neuron 0 in the low byte
F2F4F6F8FAFCFE00
F3F5F7F9FBFDFF01
F4F6F8FAFCFE0002
F5F7F9FBFDFF0103
F6F8FAFCFE000204
F7F9FBFDFF010305
F8FAFCFE00020406
F9FBFDFF01030507
FAFCFE0002040608
FBFDFF0103050709
FCFE00020406080A
FDFF01030507090B
FE00020406080A0C
FF01030507090B0D
00020406080A0C0E
01030507090B0D0F
0403020100FFFEFD

//--- sim/dense_layer_golden.txt
# Per image: pixel bits with pixel 0 leftmost, then idle cycles before each pixel strobe,
# then expected set_count in decimal and results of neurons 0 to 7 in 16 bit hex
0000000000000000
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0003 0002 0001 0000 FFFF FFFE FFFD FFFC

1111111111111111
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
16 007B 005A 0039 0018 FFF7 FFD6 FFB5 FF94

1010000000000001
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0014 000D 0006 FFFF FFF8 FFF1 FFEA FFE3

1010000000000001
2 0 1 3 0 0 2 1 0 3 1 0 0 2 1 1
3 0014 000D 0006 FFFF FFF8 FFF1 FFEA FFE3

0000111100001111
1 1 0 2 0 3 0 0 1 2 0 1 3 0 0 2
8 004F 003E 002D 001C 000B FFFA FFE9 FFD8

0000111100001111
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8 004F 003E 002D 001C 000B FFFA FFE9 FFD8

0110100110010110
0 3 1 0 2 0 0 1 1 0 2 3 0 1 0 0
8 003F 002E 001D 000C FFFB FFEA FFD9 FFC8

0000000000000000
3 0 0 1 0 2 0 0 0 1 0 0 2 0 0 1
0 0003 0002 0001 0000 FFFF FFFE FFFD FFFC

//--- vlog.f
verilog/dense_pkg.sv
verilog/mac_if.sv
verilog/pixel_sequencer.sv
verilog/neuron_mac.sv
verilog/bias_drain.sv
verilog/dense_layer.sv
sim/dense_layer_props.sv
sim/dense_layer_tb.sv

//--- run.sh
#!/bin/sh
# Build the dense layer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module dense_layer_tb -o dense_layer_sim \
  && ./obj_dir/dense_layer_sim | tee /dev/stderr | grep -F "*** PASSED ***" > /dev/null \
  && echo "Simulation run succeeded" \
  || { echo "Simulation run failed"; exit 1; }
